// File: build.f
elevator_pkg.sv
request_latch.sv
request_queue.sv
dispatch_control.sv
floor_logic_top.sv
floor_logic_sva.sv
tb_floor_logic.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_floor_logic
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator exit code is not trusted alone
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_floor_logic.sv
// Directed testbench with clock, reset, car model, behavior tasks, monitor and watchdog

`timescale 1ns/100ps

module tb_floor_logic;

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int ACT_LIMIT    = 20;
    localparam int NUM_TRIPS    = 14;
    localparam int TRIP_CYCLES  = 2 * elevator_pkg::NUM_FLOORS + 10;
    localparam int OTHER_CYCLES = 120;
    localparam int WATCHDOG_NS  = 2 * (NUM_TRIPS * TRIP_CYCLES + OTHER_CYCLES) * CLK_PERIOD;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t floor_call_buttons;
    elevator_pkg::floor_mask_t panel_buttons;
    logic                      door_open_btn;
    logic                      door_close_btn;
    logic                      emergency_btn;
    logic                      power_switch;
    elevator_pkg::floor_t      current_floor;
    logic                      elevator_moving;
    elevator_pkg::floor_t      elevator_floor_selector;
    logic                      direction_up;
    logic                      activate_elevator;
    elevator_pkg::floor_mask_t call_button_lights;
    elevator_pkg::floor_mask_t panel_button_lights;
    logic                      door_open_allowed;
    logic                      door_close_allowed;

    int   errors;
    int   monitor_errors = 0;
    logic power_last     = 1'b1;
    logic arrive_last    = 1'b0;

    floor_logic_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // Helpers and car model
    ////////////////////

    task automatic step();
        @(posedge clock);
        #(DRIVE_DELAY);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("Fail at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
    endtask

    function automatic elevator_pkg::floor_t offset_floor(input elevator_pkg::floor_t base,
                                                          input int k);
        return elevator_pkg::floor_t'((int'(base) + k) % elevator_pkg::NUM_FLOORS);
    endfunction

    task automatic press_panel(input elevator_pkg::floor_t f);
        panel_buttons = elevator_pkg::floor_mask_t'(1) << f;
        step();
        panel_buttons = '0;
    endtask

    task automatic press_call(input elevator_pkg::floor_t f);
        floor_call_buttons = elevator_pkg::floor_mask_t'(1) << f;
        step();
        floor_call_buttons = '0;
    endtask

    task automatic wait_for_activate();
        int n;
        n = 0;
        while (!activate_elevator && n < ACT_LIMIT) begin
            step();
            n++;
        end
        if (!activate_elevator) begin
            errors++;
            $display("activate_elevator did not rise within %0d cycles at %0t ns", ACT_LIMIT, $time);
        end
    endtask

    // Car climbs or descends one floor per cycle, then stops
    task automatic move_car(input elevator_pkg::floor_t target);
        elevator_moving = 1'b1;
        step();
        while (current_floor != target) begin
            if (current_floor < target) begin
                current_floor = current_floor + 1'b1;
            end else begin
                current_floor = current_floor - 1'b1;
            end
            step();
        end
        elevator_moving = 1'b0;
    endtask

    task automatic serve_trip(input elevator_pkg::floor_t target);
        logic up_exp;
        wait_for_activate();
        up_exp = (target > current_floor);
        if (elevator_floor_selector !== target) begin
            report_mismatch("elevator_floor_selector", int'(target), int'(elevator_floor_selector));
        end
        if (direction_up !== up_exp) begin
            report_mismatch("direction_up", int'(up_exp), int'(direction_up));
        end
        move_car(target);
        // ARRIVED at the first edge, lights clear at the second
        repeat (2) step();
        if (panel_button_lights[target] !== 1'b0) begin
            report_mismatch("panel_button_lights bit", 0, int'(panel_button_lights[target]));
        end
        if (call_button_lights[target] !== 1'b0) begin
            report_mismatch("call_button_lights bit", 0, int'(call_button_lights[target]));
        end
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
    endtask

    ////////////////////
    // Behaviors
    ////////////////////

    task automatic check_after_reset();
        if (panel_button_lights !== '0 || call_button_lights !== '0) begin
            report_mismatch("button lights", 0, int'(panel_button_lights | call_button_lights));
        end
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b0) begin
            report_mismatch("door permissions", 0, int'({door_open_allowed, door_close_allowed}));
        end
    endtask

    task automatic single_request();
        press_panel(elevator_pkg::floor_t'(5));
        if (panel_button_lights[5] !== 1'b1) begin
            report_mismatch("panel_button_lights bit", 1, int'(panel_button_lights[5]));
        end
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
        step();
        if (activate_elevator !== 1'b1) begin
            report_mismatch("activate_elevator", 1, int'(activate_elevator));
        end
        serve_trip(elevator_pkg::floor_t'(5));
    endtask

    task automatic order_and_duplicates();
        elevator_pkg::floor_t floors [10];
        elevator_pkg::floor_t tmp;
        int                   n;
        int                   j;
        n = 0;
        for (int f = 0; f < elevator_pkg::NUM_FLOORS; f++) begin
            if (elevator_pkg::floor_t'(f) != current_floor) begin
                floors[n] = elevator_pkg::floor_t'(f);
                n++;
            end
        end
        for (int i = 9; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            tmp = floors[i];
            floors[i] = floors[j];
            floors[j] = tmp;
        end
        // One floor dispatched at once, the next eight fill the FIFO
        for (int i = 0; i < 9; i++) begin
            press_panel(floors[i]);
            if (panel_button_lights[floors[i]] !== 1'b1) begin
                report_mismatch("panel_button_lights bit", 1, int'(panel_button_lights[floors[i]]));
            end
            if (i < 3) begin
                press_call(floors[i]);
                if (call_button_lights[floors[i]] !== 1'b1) begin
                    report_mismatch("call_button_lights bit", 1,
                                    int'(call_button_lights[floors[i]]));
                end
            end
        end
        press_panel(floors[9]);
        if (panel_button_lights[floors[9]] !== 1'b0) begin
            report_mismatch("panel_button_lights bit", 0, int'(panel_button_lights[floors[9]]));
        end
        for (int i = 0; i < 9; i++) begin
            serve_trip(floors[i]);
        end
        repeat (4) step();
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
        if (panel_button_lights !== '0 || call_button_lights !== '0) begin
            report_mismatch("button lights", 0, int'(panel_button_lights | call_button_lights));
        end
    endtask

    task automatic press_at_current_floor();
        panel_buttons      = elevator_pkg::floor_mask_t'(1) << current_floor;
        floor_call_buttons = elevator_pkg::floor_mask_t'(1) << current_floor;
        step();
        panel_buttons      = '0;
        floor_call_buttons = '0;
        repeat (3) step();
        if (panel_button_lights !== '0 || call_button_lights !== '0) begin
            report_mismatch("button lights", 0, int'(panel_button_lights | call_button_lights));
        end
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
    endtask

    task automatic emergency_and_power();
        elevator_pkg::floor_t a;
        elevator_pkg::floor_t b;
        elevator_pkg::floor_t c;
        a = offset_floor(current_floor, 3);
        b = offset_floor(current_floor, 6);
        c = offset_floor(current_floor, 8);
        press_panel(a);
        press_panel(b);
        emergency_btn = 1'b1;
        repeat (2) step();
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
        press_panel(c);
        step();
        if (panel_button_lights[c] !== 1'b0) begin
            report_mismatch("panel_button_lights bit", 0, int'(panel_button_lights[c]));
        end
        if (panel_button_lights[a] !== 1'b1 || panel_button_lights[b] !== 1'b1) begin
            report_mismatch("kept panel lights", 3,
                            int'({panel_button_lights[a], panel_button_lights[b]}));
        end
        emergency_btn = 1'b0;
        serve_trip(a);
        serve_trip(b);

        // Power loss drops the pending trip and the queued floor
        press_panel(offset_floor(current_floor, 2));
        press_panel(offset_floor(current_floor, 4));
        power_switch = 1'b0;
        repeat (2) step();
        if (panel_button_lights !== '0 || call_button_lights !== '0) begin
            report_mismatch("button lights", 0, int'(panel_button_lights | call_button_lights));
        end
        power_switch = 1'b1;
        repeat (6) step();
        if (activate_elevator !== 1'b0) begin
            report_mismatch("activate_elevator", 0, int'(activate_elevator));
        end
    endtask

    task automatic door_permission();
        door_open_btn = 1'b1;
        step();
        if (door_open_allowed !== 1'b1 || door_close_allowed !== 1'b0) begin
            report_mismatch("door permissions", 2, int'({door_open_allowed, door_close_allowed}));
        end
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        step();
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b1) begin
            report_mismatch("door permissions", 1, int'({door_open_allowed, door_close_allowed}));
        end
        door_open_btn   = 1'b1;
        elevator_moving = 1'b1;
        step();
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b0) begin
            report_mismatch("door permissions", 0, int'({door_open_allowed, door_close_allowed}));
        end
        door_open_btn   = 1'b0;
        door_close_btn  = 1'b0;
        elevator_moving = 1'b0;
        step();
    endtask

    ////////////////////
    // Monitor, watchdog and main sequence
    ////////////////////

    // Sampled at the falling edge, away from the DUT's register updates
    always @(negedge clock) begin
        if (reset_n) begin
            if (!power_last && activate_elevator) begin
                monitor_errors++;
                $display("activate_elevator rose after power was off at %0t ns", $time);
            end
            if (arrive_last && dut_i.arrive_clear) begin
                monitor_errors++;
                $display("arrive_clear lasted more than one cycle at %0t ns", $time);
            end
            if (dut_i.queue_full && dut_i.push) begin
                monitor_errors++;
                $display("A request was pushed into a full queue at %0t ns", $time);
            end
        end
        power_last  = power_switch;
        arrive_last = dut_i.arrive_clear;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, "", 0);
        void'($urandom(90));
        errors             = 0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        elevator_moving    = 1'b0;
        repeat (2) @(posedge clock);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        check_after_reset();
        single_request();
        order_and_duplicates();
        press_at_current_floor();
        emergency_and_power();
        door_permission();

        $display("Errors: %0d (directed %0d, monitor %0d)",
                 errors + monitor_errors, errors, monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: floor_logic_sva.sv
// Bound assertions on power gating of travel, arrival pulse width and the FIFO push guard

`timescale 1ns/100ps

module floor_logic_sva (
    input logic clock,
    input logic reset_n,
    input logic power_switch,
    input logic activate_elevator,
    input logic arrive_clear,
    input logic push,
    input logic queue_full
);

    // Travel is dropped at the edge that sees power off
    property no_travel_without_power;
        @(posedge clock) disable iff (!reset_n)
            !power_switch |=> !activate_elevator;
    endproperty

    // Lights of the target floor are cleared by a single pulse
    property arrive_pulse_single;
        @(posedge clock) disable iff (!reset_n)
            arrive_clear |=> !arrive_clear;
    endproperty

    property no_push_when_full;
        @(posedge clock) disable iff (!reset_n)
            queue_full |-> !push;
    endproperty

    assert property (no_travel_without_power)
        else $error("activate_elevator high after power_switch was low");
    assert property (arrive_pulse_single)
        else $error("arrive_clear held longer than one cycle");
    assert property (no_push_when_full)
        else $error("push while queue_full is high");

endmodule

bind floor_logic_top floor_logic_sva floor_logic_sva_i (
    .clock             (clock),
    .reset_n           (reset_n),
    .power_switch      (power_switch),
    .activate_elevator (activate_elevator),
    .arrive_clear      (arrive_clear),
    .push              (push),
    .queue_full        (queue_full)
);

// File: floor_logic_top.sv
// Top level of the floor request controller, joining latch, FIFO and dispatch FSM

`timescale 1ns/100ps

module floor_logic_top (
    input  logic                     clock,
    input  logic                     reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                     door_open_btn,
    input  logic                     door_close_btn,
    input  logic                     emergency_btn,
    input  logic                     power_switch,
    input  elevator_pkg::floor_t     current_floor,
    input  logic                     elevator_moving,
    output elevator_pkg::floor_t     elevator_floor_selector,
    output logic                     direction_up,
    output logic                     activate_elevator,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights,
    output logic                     door_open_allowed,
    output logic                     door_close_allowed
);

    // Latch to FIFO
    logic                 push;
    elevator_pkg::floor_t push_floor;
    logic                 queue_full;

    // FIFO to dispatch
    elevator_pkg::floor_t head_floor;
    logic                 queue_empty;
    logic                 pop;

    // Dispatch back to latch and FIFO
    logic                 request_enable;
    logic                 flush;
    logic                 arrive_clear;
    elevator_pkg::floor_t arrive_floor;

    request_latch request_latch_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .request_enable      (request_enable),
        .flush               (flush),
        .arrive_clear        (arrive_clear),
        .arrive_floor        (arrive_floor),
        .queue_full          (queue_full),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .push                (push),
        .push_floor          (push_floor)
    );

    request_queue request_queue_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .push        (push),
        .push_floor  (push_floor),
        .pop         (pop),
        .flush       (flush),
        .head_floor  (head_floor),
        .queue_empty (queue_empty),
        .queue_full  (queue_full)
    );

    dispatch_control dispatch_control_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .elevator_moving         (elevator_moving),
        .current_floor           (current_floor),
        .head_floor              (head_floor),
        .queue_empty             (queue_empty),
        .pop                     (pop),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_up            (direction_up),
        .activate_elevator       (activate_elevator),
        .request_enable          (request_enable),
        .flush                   (flush),
        .arrive_clear            (arrive_clear),
        .arrive_floor            (arrive_floor),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

// File: dispatch_control.sv
// Dispatch FSM with arrival detection, power and emergency halt, and door permissions

`timescale 1ns/100ps

module dispatch_control (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 power_switch,
    input  logic                 emergency_btn,
    input  logic                 door_open_btn,
    input  logic                 door_close_btn,
    input  logic                 elevator_moving,
    input  elevator_pkg::floor_t current_floor,
    input  elevator_pkg::floor_t head_floor,
    input  logic                 queue_empty,
    output logic                 pop,
    output elevator_pkg::floor_t elevator_floor_selector,
    output logic                 direction_up,
    output logic                 activate_elevator,
    output logic                 request_enable,
    output logic                 flush,
    output logic                 arrive_clear,
    output elevator_pkg::floor_t arrive_floor,
    output logic                 door_open_allowed,
    output logic                 door_close_allowed
);

    elevator_pkg::dispatch_state_e state;
    elevator_pkg::dispatch_state_e next_state;
    elevator_pkg::floor_t          target;
    elevator_pkg::floor_t          start_floor;
    logic                          run_ok;
    logic                          can_start;
    logic                          start;
    logic                          resume;
    logic                          power_q;

    ////////////////////
    // Dispatch decision
    ////////////////////

    assign run_ok    = power_switch && !emergency_btn;
    assign can_start = (state == elevator_pkg::IDLE) && run_ok && !elevator_moving;

    // A trip cut short by emergency is resumed before the FIFO is read
    assign start       = can_start && (resume || !queue_empty);
    assign pop         = can_start && !resume && !queue_empty;
    assign start_floor = resume ? target : head_floor;

    always_comb begin
        next_state = state;
        if (!run_ok) begin
            next_state = elevator_pkg::HALT;
        end else begin
            case (state)
                elevator_pkg::IDLE: begin
                    if (start) begin
                        next_state = elevator_pkg::TRAVEL;
                    end
                end
                elevator_pkg::TRAVEL: begin
                    if (!elevator_moving && (current_floor == target)) begin
                        next_state = elevator_pkg::ARRIVED;
                    end
                end
                elevator_pkg::ARRIVED: next_state = elevator_pkg::IDLE;
                elevator_pkg::HALT:    next_state = elevator_pkg::IDLE;
                default:               next_state = elevator_pkg::IDLE;
            endcase
        end
    end

    ////////////////////
    // State and target registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= elevator_pkg::IDLE;
            target       <= '0;
            direction_up <= 1'b0;
            resume       <= 1'b0;
            power_q      <= 1'b0;
            flush        <= 1'b0;
        end else begin
            state   <= next_state;
            power_q <= power_switch;
            // One-cycle flush on the falling edge of power
            flush   <= power_q && !power_switch;
            if (start) begin
                target       <= start_floor;
                direction_up <= (start_floor > current_floor);
            end
            if (!power_switch || start) begin
                resume <= 1'b0;
            end else if ((state == elevator_pkg::TRAVEL) && emergency_btn) begin
                resume <= 1'b1;
            end
        end
    end

    assign activate_elevator       = (state == elevator_pkg::TRAVEL);
    assign arrive_clear            = (state == elevator_pkg::ARRIVED);
    assign request_enable          = run_ok && (state != elevator_pkg::HALT);
    assign elevator_floor_selector = target;
    assign arrive_floor            = target;

    ////////////////////
    // Door permission
    ////////////////////

    // Doors only respond with power on and the car stopped
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= power_switch && !elevator_moving && door_open_btn;
            door_close_allowed <= power_switch && !elevator_moving && door_close_btn;
        end
    end

endmodule

// File: request_queue.sv
// Circular FIFO of requested floor numbers with full and empty flags

`timescale 1ns/100ps

module request_queue (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 push,
    input  elevator_pkg::floor_t push_floor,
    input  logic                 pop,
    input  logic                 flush,
    output elevator_pkg::floor_t head_floor,
    output logic                 queue_empty,
    output logic                 queue_full
);

    elevator_pkg::floor_t                 mem [elevator_pkg::QUEUE_DEPTH];
    logic [elevator_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [elevator_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [elevator_pkg::QUEUE_PTR_W:0]   count;
    logic                                 do_push;
    logic                                 do_pop;

    ////////////////////
    // Status
    ////////////////////

    assign queue_empty = (count == '0);
    assign queue_full  = (count == (elevator_pkg::QUEUE_PTR_W + 1)'(elevator_pkg::QUEUE_DEPTH));

    // Guard against overflow and underflow
    assign do_push = push && !queue_full;
    assign do_pop  = pop && !queue_empty;

    // Head entry is visible without a pop
    assign head_floor = mem[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_floor;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: request_latch.sv
// Button scanning, panel and call light registers, and request push toward the queue

`timescale 1ns/100ps

module request_latch (
    input  logic                     clock,
    input  logic                     reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  elevator_pkg::floor_t     current_floor,
    input  logic                     request_enable,
    input  logic                     flush,
    input  logic                     arrive_clear,
    input  elevator_pkg::floor_t     arrive_floor,
    input  logic                     queue_full,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights,
    output logic                     push,
    output elevator_pkg::floor_t     push_floor
);

    // Lowest set bit wins
    function automatic elevator_pkg::floor_t lowest_set(input elevator_pkg::floor_mask_t mask);
        elevator_pkg::floor_t idx;
        idx = '0;
        for (int i = elevator_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = elevator_pkg::floor_t'(i);
            end
        end
        return idx;
    endfunction

    elevator_pkg::floor_mask_t here_mask;
    elevator_pkg::floor_mask_t panel_cand;
    elevator_pkg::floor_mask_t call_cand;
    elevator_pkg::floor_mask_t take_mask;
    elevator_pkg::floor_mask_t clear_mask;
    elevator_pkg::floor_t      take_floor;
    logic                      take_en;
    logic                      take_panel;
    logic                      take_call;
    logic                      already_lit;

    ////////////////////
    // Button scan
    ////////////////////

    // A press at the floor the car sits on is ignored
    assign here_mask  = elevator_pkg::floor_mask_t'(1) << current_floor;
    assign panel_cand = panel_buttons & ~panel_button_lights & ~here_mask;
    assign call_cand  = floor_call_buttons & ~call_button_lights & ~here_mask;

    // Nothing new is taken while the FIFO is full, held buttons wait
    assign take_en    = request_enable && !queue_full;
    assign take_panel = take_en && (|panel_cand);
    assign take_call  = take_en && !(|panel_cand) && (|call_cand);
    assign take_floor = (|panel_cand) ? lowest_set(panel_cand) : lowest_set(call_cand);
    assign take_mask  = elevator_pkg::floor_mask_t'(1) << take_floor;

    // Second button of a floor only lights, the floor is queued once
    assign already_lit = |((panel_button_lights | call_button_lights) & take_mask);
    assign push        = (take_panel || take_call) && !already_lit;
    assign push_floor  = take_floor;

    ////////////////////
    // Light registers
    ////////////////////

    assign clear_mask = arrive_clear ? (elevator_pkg::floor_mask_t'(1) << arrive_floor) : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (flush) begin
            // Power loss drops every request
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else begin
            panel_button_lights <= (panel_button_lights & ~clear_mask)
                                   | (take_panel ? take_mask : '0);
            call_button_lights  <= (call_button_lights & ~clear_mask)
                                   | (take_call ? take_mask : '0);
        end
    end

endmodule

// File: elevator_pkg.sv
// Floor constants, queue sizing, floor types and the dispatch state encoding

package elevator_pkg;

    ////////////////////
    // Building and queue sizing
    ////////////////////

    // Floors are numbered 0 to NUM_FLOORS-1
    localparam int NUM_FLOORS  = 11;
    localparam int FLOOR_W     = 4;

    // Pending request FIFO
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;

    ////////////////////
    // Types
    ////////////////////

    // Binary floor number, only 0 to 10 are legal
    typedef logic [FLOOR_W-1:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Dispatch FSM states
    typedef enum logic [1:0] {
        IDLE,      // Stopped, waiting for a request
        TRAVEL,    // Car released toward the target floor
        ARRIVED,   // One cycle at the target, lights cleared
        HALT       // Power off or emergency stop
    } dispatch_state_e;

    // HALT is left only when power is on and emergency is released
    // IDLE, TRAVEL and ARRIVED all accept new requests

endpackage
